// File: bench/tb_lsu_subsystem.sv
/*
 * Testbench for the load/store subsystem
 * Random loads and stores against a byte reference memory checked by assertions
 */
module tb_lsu_subsystem
    import lsu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OPS     = 104;
    localparam int CYCLE_LIMIT = NUM_OPS * 20 + 200;

    logic        clock, reset, in_valid, in_ready, in_mem_ren, in_mem_wen, in_reg_wen;
    logic [2:0]  in_funct3;
    logic [31:0] in_addr, in_store_data, out_result;
    logic [4:0]  in_rd, out_rd;
    logic        out_valid, out_ready, out_reg_wen, out_mem_error;

    logic [7:0]  ref_mem [MEM_BYTES];
    logic [31:0] exp_result;
    logic [4:0]  exp_rd;
    logic        exp_reg_wen, exp_error;
    integer      seed = 32'h17d549a9;
    int          value_errors = 0, handshake_errors = 0, ops_done = 0, cycle_count = 0;

    lsu_subsystem u_lsu_subsystem (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        value_errors++;
        $display("CHECK FAILED %s: got %h expected %h", name, got, expected);
    endtask

    a_reset_state: assert property (@(posedge clock) $fell(reset) |-> !out_valid && in_ready)
        else report_value("out_valid,in_ready", 32'({$sampled(out_valid), $sampled(in_ready)}),
                          32'h1);
    a_result: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> out_result == exp_result)
        else report_value("out_result", $sampled(out_result), $sampled(exp_result));
    a_rd: assert property (@(posedge clock) disable iff (reset) out_valid |-> out_rd == exp_rd)
        else report_value("out_rd", 32'($sampled(out_rd)), 32'($sampled(exp_rd)));
    a_reg_wen: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> out_reg_wen == exp_reg_wen)
        else report_value("out_reg_wen", 32'($sampled(out_reg_wen)), 32'($sampled(exp_reg_wen)));
    a_mem_error: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> out_mem_error == exp_error)
        else report_value("out_mem_error", 32'($sampled(out_mem_error)), 32'($sampled(exp_error)));

    // Pass-through result one cycle after acceptance
    a_pass_through: assert property (@(posedge clock) disable iff (reset)
        in_valid && in_ready && !in_mem_ren && !in_mem_wen |=> out_valid)
        else begin
            handshake_errors++;
            $display("out_valid did not rise the cycle after a pass-through was accepted");
        end
    a_hold: assert property (@(posedge clock) disable iff (reset) out_valid && !out_ready
        |-> !in_ready ##1 (out_valid && $stable(out_result) && $stable(out_rd) && !in_ready))
        else begin
            handshake_errors++;
            $display("Result or in_ready changed while out_ready was low");
        end
    a_release: assert property (@(posedge clock) disable iff (reset)
        out_valid && out_ready |=> in_ready && !out_valid)
        else begin
            handshake_errors++;
            $display("in_ready did not rise the cycle after the downstream transfer");
        end

    function automatic logic [31:0] rand_word_addr();
        return ({$random(seed)} % MEM_WORDS) * 4;
    endfunction

    // Value a load sees under the funct3 extension rule
    function automatic logic [31:0] expected_load(input logic [31:0] addr, input logic [2:0] f3);
        logic [MEM_INDEX_W+1:0] a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        if (addr >= MEM_BYTES)
            return 32'h0;
        a = addr[MEM_INDEX_W+1:0];
        b = ref_mem[a];
        h = {ref_mem[{a[MEM_INDEX_W+1:1], 1'b1}], ref_mem[{a[MEM_INDEX_W+1:1], 1'b0}]};
        w = {ref_mem[{a[MEM_INDEX_W+1:2], 2'd3}], ref_mem[{a[MEM_INDEX_W+1:2], 2'd2}],
             ref_mem[{a[MEM_INDEX_W+1:2], 2'd1}], ref_mem[{a[MEM_INDEX_W+1:2], 2'd0}]};
        case (f3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'h0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'h0, h};
            F3_W:    return w;
            default: return 32'h0;
        endcase
    endfunction

    function automatic void update_ref_mem(input logic [31:0] addr, input logic [2:0] f3,
                                           input logic [31:0] data);
        logic [MEM_INDEX_W+1:0] a;
        int nbytes;
        if (addr >= MEM_BYTES)
            return;  // Out-of-range store leaves memory untouched
        nbytes = (f3 == F3_W) ? 4 : (f3 == F3_H) ? 2 : 1;
        a = addr[MEM_INDEX_W+1:0];
        for (int i = 0; i < nbytes; i++)
            ref_mem[a + i[MEM_INDEX_W+1:0]] = data[i*8 +: 8];
    endfunction

    // One operation through both handshakes with out_ready sometimes held back
    task automatic run_op(input logic ren, input logic wen, input logic [2:0] f3,
                          input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rnd;
        int hold_cycles;
        rnd = $random(seed);
        hold_cycles = {$random(seed)} % 4;
        while (!in_ready) @(negedge clock);
        exp_rd      = rnd[4:0];
        exp_reg_wen = (ren || wen) ? ren : rnd[5];
        exp_error   = (ren || wen) && (addr >= MEM_BYTES);
        exp_result  = ren ? expected_load(addr, f3) : addr;
        if (wen)
            update_ref_mem(addr, f3, data);
        in_valid      = 1'b1;
        in_mem_ren    = ren;
        in_mem_wen    = wen;
        in_funct3     = f3;
        in_addr       = addr;
        in_store_data = data;
        in_rd         = exp_rd;
        in_reg_wen    = exp_reg_wen;
        out_ready = (hold_cycles == 0);
        @(negedge clock);
        in_valid = 1'b0;
        while (!out_valid) @(negedge clock);
        repeat (hold_cycles) @(negedge clock);
        out_ready = 1'b1;
        @(negedge clock);
        out_ready = 1'b0;
        ops_done++;
    endtask

    initial begin
        logic [31:0] base, rnd;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_mem_ren    = 1'b0;
        in_mem_wen    = 1'b0;
        in_reg_wen    = 1'b0;
        out_ready     = 1'b0;
        in_funct3     = 3'b000;
        in_addr       = 32'h0;
        in_store_data = 32'h0;
        in_rd         = 5'd0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        for (int i = 0; i < 8; i++) begin  // Word round trip
            base = rand_word_addr();
            run_op(1'b0, 1'b1, F3_W, base, $random(seed));
            run_op(1'b1, 0, F3_W, base, 32'h0);
        end
        // Byte at each lane, halfword in the other half, then every load width
        for (int lane = 0; lane < 4; lane++) begin
            base = rand_word_addr();
            run_op(1'b0, 1'b1, F3_W, base, $random(seed));
            run_op(1'b0, 1'b1, F3_H, base + ((lane < 2) ? 2 : 0), $random(seed));
            run_op(1'b0, 1'b1, F3_B, base + lane, $random(seed));
            for (int k = 0; k < 4; k++) begin
                run_op(1'b1, 1'b0, F3_B, base + k, 32'h0);
                run_op(1'b1, 1'b0, F3_BU, base + k, 32'h0);
            end
            for (int k = 0; k < 4; k += 2) begin
                run_op(1'b1, 1'b0, F3_H, base + k, 32'h0);
                run_op(1'b1, 1'b0, F3_HU, base + k, 32'h0);
            end
            run_op(1'b1, 1'b0, F3_W, base, 32'h0);
        end
        for (int i = 0; i < 4; i++) begin  // Out-of-range accesses aliasing an in-range word
            base = rand_word_addr();
            rnd  = $random(seed);
            run_op(1'b0, 1'b1, F3_W, base, $random(seed));
            run_op(1'b0, 1'b1, F3_W, base + MEM_BYTES * (rnd[3:0] + 1), $random(seed));
            run_op(1'b1, 1'b0, F3_W, base + MEM_BYTES * (rnd[3:0] + 1), 32'h0);
            run_op(1'b1, 1'b0, F3_W, base, 32'h0);
        end
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            run_op(1'b0, 1'b0, rnd[2:0], $random(seed), $random(seed));
        end
        repeat (4) @(negedge clock);
        $display("Summary: %0d operations, %0d value errors, %0d handshake errors",
                 ops_done, value_errors, handshake_errors);
        if (value_errors == 0 && handshake_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: common/axi_mem_if.sv
/*
 * Single-beat AXI4 link between the load/store stage and the SRAM
 */
interface axi_mem_if;

    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;

    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;

    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;

    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;

    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp,
        input  arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
        input  arvalid, araddr, rready,
        output awready, wready, bvalid, bresp,
        output arready, rvalid, rdata, rresp
    );

endinterface

// File: common/lsu_pkg.sv
/*
 * Load/store stage shared definitions
 * Width codes, AXI responses, SRAM size and the data word views
 */
package lsu_pkg;

    // RISC-V funct3 width codes for loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam int unsigned MEM_WORDS   = 256;
    localparam int unsigned MEM_BYTES   = MEM_WORDS * 4;  // First out-of-range address
    localparam int unsigned MEM_INDEX_W = $clog2(MEM_WORDS);

    // One data word seen as byte lanes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  lanes;
        logic [1:0][15:0] halves;
    } mem_word_t;

endpackage

// File: filelist.f
common/lsu_pkg.sv
common/axi_mem_if.sv
lsu/lsu_byte_lane.sv
lsu/lsu_stage.sv
src/axi_sram.sv
src/lsu_subsystem.sv
bench/tb_lsu_subsystem.sv

// File: lsu/lsu_byte_lane.sv
/*
 * Byte lane steering for the load/store stage
 * Store alignment with strobes, load selection with sign or zero extension
 */
module lsu_byte_lane
    import lsu_pkg::*;
(
    input  logic [2:0]  funct3,
    input  logic [1:0]  addr_low,
    input  logic [31:0] store_data,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    input  mem_word_t   rdata,
    output logic [31:0] load_data
);

    mem_word_t   store_word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    always_comb begin
        store_word = '0;
        wstrb      = 4'b0000;
        case (funct3)
            F3_B: begin
                store_word.lanes[addr_low] = store_data[7:0];
                wstrb[addr_low]            = 1'b1;
            end
            F3_H: begin
                store_word.halves[addr_low[1]] = store_data[15:0];
                wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            F3_W: begin
                store_word = store_data;
                wstrb      = 4'b1111;
            end
            default: ;  // No strobes, nothing written
        endcase
    end

    assign wdata = store_word;

    assign sel_byte = rdata.lanes[addr_low];
    assign sel_half = rdata.halves[addr_low[1]];

    always_comb begin
        case (funct3)
            F3_B:    load_data = {{24{sel_byte[7]}}, sel_byte};
            F3_H:    load_data = {{16{sel_half[15]}}, sel_half};
            F3_W:    load_data = rdata;
            F3_BU:   load_data = {24'd0, sel_byte};
            F3_HU:   load_data = {16'd0, sel_half};
            default: load_data = '0;
        endcase
    end

endmodule

// File: lsu/lsu_stage.sv
/*
 * Memory-access pipeline stage
 * Takes one operation at a time, runs it over AXI and hands the result on
 */
module lsu_stage
    import lsu_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    input  logic        in_valid,
    output logic        in_ready,
    input  logic        in_mem_ren,
    input  logic        in_mem_wen,
    input  logic [2:0]  in_funct3,
    input  logic [31:0] in_addr,
    input  logic [31:0] in_store_data,
    input  logic [4:0]  in_rd,
    input  logic        in_reg_wen,

    output logic        out_valid,
    input  logic        out_ready,
    output logic [4:0]  out_rd,
    output logic        out_reg_wen,
    output logic [31:0] out_result,
    output logic        out_mem_error,

    axi_mem_if.master   mem
);

    logic        accept;
    logic        r_done;
    logic        b_done;
    logic        out_done;

    logic        mem_ren_q;
    logic [2:0]  funct3_q;
    logic [31:0] addr_q;
    logic [31:0] store_data_q;
    logic [4:0]  rd_q;
    logic        reg_wen_q;

    logic [31:0] load_data;
    logic [31:0] load_q;

    assign accept   = in_valid & in_ready;
    assign r_done   = mem.rvalid & mem.rready;
    assign b_done   = mem.bvalid & mem.bready;
    assign out_done = out_valid & out_ready;

    always_ff @(posedge clock) begin
        if (accept) begin
            mem_ren_q    <= in_mem_ren;
            funct3_q     <= in_funct3;
            addr_q       <= in_addr;
            store_data_q <= in_store_data;
            rd_q         <= in_rd;
            reg_wen_q    <= in_reg_wen;
        end
    end

    // Upstream and downstream handshakes, one operation in flight
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            in_ready  <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            if (accept)
                in_ready <= 1'b0;
            else if (out_done)
                in_ready <= 1'b1;

            if (accept && !(in_mem_ren || in_mem_wen))
                out_valid <= 1'b1;  // Pass-through
            else if (r_done || b_done)
                out_valid <= 1'b1;
            else if (out_done)
                out_valid <= 1'b0;
        end
    end

    // Each channel signal drops on its own transfer
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mem.awvalid <= 1'b0;
            mem.wvalid  <= 1'b0;
            mem.bready  <= 1'b0;
            mem.arvalid <= 1'b0;
            mem.rready  <= 1'b0;
        end else if (accept) begin
            mem.awvalid <= in_mem_wen;
            mem.wvalid  <= in_mem_wen;
            mem.bready  <= in_mem_wen;
            mem.arvalid <= in_mem_ren;
            mem.rready  <= in_mem_ren;
        end else begin
            if (mem.awvalid && mem.awready)
                mem.awvalid <= 1'b0;
            if (mem.wvalid && mem.wready)
                mem.wvalid <= 1'b0;
            if (b_done)
                mem.bready <= 1'b0;
            if (mem.arvalid && mem.arready)
                mem.arvalid <= 1'b0;
            if (r_done)
                mem.rready <= 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            out_mem_error <= 1'b0;
        else if (accept)
            out_mem_error <= 1'b0;
        else if (r_done)
            out_mem_error <= (mem.rresp == RESP_SLVERR);
        else if (b_done)
            out_mem_error <= (mem.bresp == RESP_SLVERR);
    end

    always_ff @(posedge clock) begin
        if (r_done)
            load_q <= load_data;
    end

    assign mem.awaddr = addr_q;
    assign mem.araddr = addr_q;

    assign out_rd      = rd_q;
    assign out_reg_wen = reg_wen_q;
    assign out_result  = mem_ren_q ? load_q : addr_q;

    lsu_byte_lane u_byte_lane (
        .funct3     (funct3_q),
        .addr_low   (addr_q[1:0]),
        .store_data (store_data_q),
        .wdata      (mem.wdata),
        .wstrb      (mem.wstrb),
        .rdata      (mem.rdata),
        .load_data  (load_data)
    );

endmodule

// File: src/axi_sram.sv
/*
 * On-chip SRAM behind a single-beat AXI4 slave port
 * Fixed read delay, SLVERR above the array
 */
module axi_sram
    import lsu_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    axi_mem_if.slave mem
);

    logic [31:0] mem_array [MEM_WORDS];

    logic [1:0]  rd_delay;
    logic        rvalid_q;
    logic [31:0] araddr_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;
    logic        rd_in_range;

    logic        aw_got;
    logic        w_got;
    logic [31:0] awaddr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        wr_in_range;

    assign rd_in_range = araddr_q < MEM_BYTES;
    assign wr_in_range = awaddr_q < MEM_BYTES;

    // Read side
    assign mem.arready = (rd_delay == 2'd0) & ~rvalid_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_delay <= 2'd0;
            rvalid_q <= 1'b0;
        end else begin
            if (mem.arvalid && mem.arready)
                rd_delay <= 2'd2;
            else if (rd_delay != 2'd0)
                rd_delay <= rd_delay - 2'd1;

            if (rd_delay == 2'd1)
                rvalid_q <= 1'b1;
            else if (rvalid_q && mem.rready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (mem.arvalid && mem.arready)
            araddr_q <= mem.araddr;
        if (rd_delay == 2'd1) begin
            rdata_q <= rd_in_range ? mem_array[araddr_q[MEM_INDEX_W+1:2]] : 32'd0;
            rresp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Write side, aw and w may arrive apart
    assign mem.awready = ~aw_got & ~bvalid_q;
    assign mem.wready  = ~w_got & ~bvalid_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            bvalid_q <= 1'b0;
        end else if (aw_got && w_got) begin
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            bvalid_q <= 1'b1;
        end else begin
            if (mem.awvalid && mem.awready)
                aw_got <= 1'b1;
            if (mem.wvalid && mem.wready)
                w_got <= 1'b1;
            if (bvalid_q && mem.bready)
                bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (mem.awvalid && mem.awready)
            awaddr_q <= mem.awaddr;
        if (mem.wvalid && mem.wready) begin
            wdata_q <= mem.wdata;
            wstrb_q <= mem.wstrb;
        end
        if (aw_got && w_got) begin
            bresp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
            for (int i = 0; i < 4; i++) begin
                if (wr_in_range && wstrb_q[i])
                    mem_array[awaddr_q[MEM_INDEX_W+1:2]][i*8 +: 8] <= wdata_q[i*8 +: 8];
            end
        end
    end

    assign mem.rvalid = rvalid_q;
    assign mem.rdata  = rdata_q;
    assign mem.rresp  = rresp_q;
    assign mem.bvalid = bvalid_q;
    assign mem.bresp  = bresp_q;

endmodule

// File: src/lsu_subsystem.sv
/*
 * Load/store stage with its AXI4 SRAM
 */
module lsu_subsystem (
    input  logic        clock,
    input  logic        reset,

    input  logic        in_valid,
    output logic        in_ready,
    input  logic        in_mem_ren,
    input  logic        in_mem_wen,
    input  logic [2:0]  in_funct3,
    input  logic [31:0] in_addr,
    input  logic [31:0] in_store_data,
    input  logic [4:0]  in_rd,
    input  logic        in_reg_wen,

    output logic        out_valid,
    input  logic        out_ready,
    output logic [4:0]  out_rd,
    output logic        out_reg_wen,
    output logic [31:0] out_result,
    output logic        out_mem_error
);

    axi_mem_if u_axi ();

    lsu_stage u_lsu_stage (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_mem_ren    (in_mem_ren),
        .in_mem_wen    (in_mem_wen),
        .in_funct3     (in_funct3),
        .in_addr       (in_addr),
        .in_store_data (in_store_data),
        .in_rd         (in_rd),
        .in_reg_wen    (in_reg_wen),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_rd        (out_rd),
        .out_reg_wen   (out_reg_wen),
        .out_result    (out_result),
        .out_mem_error (out_mem_error),
        .mem           (u_axi.master)
    );

    axi_sram u_axi_sram (
        .clock (clock),
        .reset (reset),
        .mem   (u_axi.slave)
    );

endmodule
